// ==== include/mvu_pe_config.svh ====
//**********************************************************
// MVU PE configuration
// Fold geometry, data widths and APB address map
//**********************************************************
`ifndef MVU_PE_CONFIG_SVH
`define MVU_PE_CONFIG_SVH

// Fold geometry
`define MVU_SIMD      4
`define MVU_SF        4
`define MVU_ROWS      4

// Weight, activation and accumulator widths
`define MVU_TW        4
`define MVU_TI        4
`define MVU_TDST      16

// APB bus widths
`define MVU_APB_AW    12
`define MVU_APB_DW    32

// Register map, one 32-bit word per entry
`define MVU_ADDR_WGT  12'h000
`define MVU_ADDR_ACT  12'h040
`define MVU_ADDR_CTRL 12'h080
`define MVU_ADDR_STAT 12'h084

`endif

// ==== source/mvu_pe_pkg.sv ====
//**********************************************************
// MVU PE types
// Data words, APB and beat structs, sequencer states
//**********************************************************
`include "mvu_pe_config.svh"

package mvu_pe_pkg;

   // One fold of packed lanes, lane 0 in the low bits
   typedef logic [`MVU_SIMD*`MVU_TW-1:0] weight_word_t;
   typedef logic [`MVU_SIMD*`MVU_TI-1:0] act_word_t;

   // Signed weight times zero-extended activation
   typedef logic signed [`MVU_TW+`MVU_TI:0] prod_t;
   typedef logic signed [`MVU_TDST-1:0] acc_t;

   // Row/fold index into weight storage
   typedef logic [$clog2(`MVU_ROWS*`MVU_SF)-1:0] buf_addr_t;
   typedef logic [$clog2(`MVU_SF)-1:0] fold_idx_t;

   // Master side of APB
   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`MVU_APB_AW-1:0] paddr;
      logic [`MVU_APB_DW-1:0] pwdata;
   } apb_req_t;

   // Slave side of APB
   typedef struct packed {
      logic [`MVU_APB_DW-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apb_rsp_t;

   // One compute beat, flags travel with the data
   typedef struct packed {
      logic         stream;
      logic         sf_clr;
      logic         sf_end;
      weight_word_t weights;
      act_word_t    acts;
   } beat_t;

   typedef struct packed {
      logic valid;
      acc_t data;
   } result_t;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      END,
      DRAIN
   } ctrl_state_t;

endpackage

// ==== source/mvu_pe_apb_regs.sv ====
//**********************************************************
// MVU PE APB slave
// Buffer access, run start and status, zero wait states
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_apb_regs (
   input  logic                    aclk,
   input  logic                    aresetn,
   input  mvu_pe_pkg::apb_req_t    apb_req,
   output mvu_pe_pkg::apb_rsp_t    apb_rsp,
   input  logic                    busy,
   output logic                    start,
   output logic                    wr_en,
   output logic                    act_sel,
   output mvu_pe_pkg::buf_addr_t   wr_addr,
   output mvu_pe_pkg::weight_word_t wr_data,
   input  mvu_pe_pkg::weight_word_t rd_data
);
   import mvu_pe_pkg::*;

   localparam int WGT_BYTES = 4 * `MVU_ROWS * `MVU_SF;
   localparam int ACT_BYTES = 4 * `MVU_SF;
   localparam int PAD_W     = `MVU_APB_DW - $bits(weight_word_t);

   logic                   setup_q;
   logic                   access;
   logic [`MVU_APB_AW-1:0] wgt_off;
   logic [`MVU_APB_AW-1:0] act_off;
   logic                   hit_wgt;
   logic                   hit_act;
   logic                   hit_ctrl;
   logic                   hit_stat;
   logic                   start_req;

   // Remember the setup cycle so only a real access phase is decoded
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= apb_req.psel & ~apb_req.penable;
      end
   end

   assign access = apb_req.psel & apb_req.penable & setup_q;

   // Region offsets, byte addressed
   assign wgt_off  = apb_req.paddr - `MVU_ADDR_WGT;
   assign act_off  = apb_req.paddr - `MVU_ADDR_ACT;
   assign hit_wgt  = int'(wgt_off) < WGT_BYTES;
   assign hit_act  = int'(act_off) < ACT_BYTES;
   assign hit_ctrl = apb_req.paddr == `MVU_ADDR_CTRL;
   assign hit_stat = apb_req.paddr == `MVU_ADDR_STAT;

   // Start command, bit 0 of control
   assign start_req = access & apb_req.pwrite & hit_ctrl & apb_req.pwdata[0];
   assign start     = start_req & ~busy;

   // Buffer port, shared by writes and readback
   assign wr_en   = access & apb_req.pwrite & (hit_wgt | hit_act);
   assign act_sel = hit_act;
   // Word index, both region bases sit above the index bits
   assign wr_addr = apb_req.paddr[2 +: $bits(buf_addr_t)];
   assign wr_data = apb_req.pwdata[$bits(weight_word_t)-1:0];

   always_comb begin
      apb_rsp.pready  = 1'b1;
      // Unmapped address, or start while a run is in progress
      apb_rsp.pslverr = access &
                        (~(hit_wgt | hit_act | hit_ctrl | hit_stat) | (start_req & busy));
      if (hit_wgt || hit_act) begin
         apb_rsp.prdata = {{PAD_W{1'b0}}, rd_data};
      end else if (hit_stat) begin
         apb_rsp.prdata = {{(`MVU_APB_DW-1){1'b0}}, busy};
      end else begin
         apb_rsp.prdata = '0;
      end
   end

endmodule

// ==== source/mvu_pe_buffer.sv ====
//**********************************************************
// MVU PE buffer
// Weight and activation storage, registered beat read
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_buffer (
   input  logic                     aclk,
   input  logic                     aresetn,
   input  logic                     wr_en,
   input  logic                     act_sel,
   input  mvu_pe_pkg::buf_addr_t    wr_addr,
   input  mvu_pe_pkg::weight_word_t wr_data,
   output mvu_pe_pkg::weight_word_t rd_data,
   input  mvu_pe_pkg::buf_addr_t    rd_addr,
   input  mvu_pe_pkg::fold_idx_t    rd_fold,
   input  logic                     stream,
   input  logic                     sf_clr,
   input  logic                     sf_end,
   output mvu_pe_pkg::beat_t        beat
);
   import mvu_pe_pkg::*;

   localparam int WGT_DEPTH = `MVU_ROWS * `MVU_SF;
   localparam int ACT_DEPTH = `MVU_SF;

   weight_word_t wgt_mem [WGT_DEPTH];
   act_word_t    act_mem [ACT_DEPTH];

   // APB side write, storage starts out zeroed
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wgt_mem <= '{default: '0};
         act_mem <= '{default: '0};
      end else if (wr_en) begin
         if (act_sel) begin
            act_mem[wr_addr[$bits(fold_idx_t)-1:0]] <= wr_data;
         end else begin
            wgt_mem[wr_addr] <= wr_data;
         end
      end
   end

   // Readback for APB, same address as the write
   assign rd_data = act_sel ? act_mem[wr_addr[$bits(fold_idx_t)-1:0]] : wgt_mem[wr_addr];

   // Flags of the beat
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         beat.stream <= 1'b0;
         beat.sf_clr <= 1'b0;
         beat.sf_end <= 1'b0;
      end else begin
         beat.stream <= stream;
         beat.sf_clr <= sf_clr;
         beat.sf_end <= sf_end;
      end
   end

   // Beat payload, activation picked by fold
   always_ff @(posedge aclk) begin
      beat.weights <= wgt_mem[rd_addr];
      beat.acts    <= act_mem[rd_fold];
   end

endmodule

// ==== source/mvu_pe_ctrl.sv ====
//**********************************************************
// MVU PE sequencer
// Issues row/fold beats of a run and holds busy
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_ctrl (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic                  start,
   output logic                  busy,
   output mvu_pe_pkg::buf_addr_t rd_addr,
   output mvu_pe_pkg::fold_idx_t rd_fold,
   output logic                  stream,
   output logic                  sf_clr,
   output logic                  sf_end
);
   import mvu_pe_pkg::*;

   localparam int ROW_W = $clog2(`MVU_ROWS);
   localparam logic [ROW_W-1:0] ROW_LAST  = ROW_W'(`MVU_ROWS - 1);
   localparam fold_idx_t        FOLD_LAST = fold_idx_t'(`MVU_SF - 1);
   // End beat needs four cycles to reach the result port
   localparam logic [1:0]       DRAIN_LAST = 2'd3;

   ctrl_state_t      state_q;
   logic [ROW_W-1:0] row_q;
   fold_idx_t        fold_q;
   logic [1:0]       drain_q;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state_q <= IDLE;
         row_q   <= '0;
         fold_q  <= '0;
         drain_q <= '0;
      end else begin
         unique case (state_q)
            IDLE: begin
               row_q  <= '0;
               fold_q <= '0;
               if (start) begin
                  state_q <= RUN;
               end
            end
            RUN: begin
               // Fold index runs fastest
               fold_q <= fold_q + 1'b1;
               if (fold_q == FOLD_LAST) begin
                  row_q <= row_q + 1'b1;
                  if (row_q == ROW_LAST) begin
                     state_q <= END;
                  end
               end
            end
            END: begin
               drain_q <= DRAIN_LAST;
               state_q <= DRAIN;
            end
            DRAIN: begin
               drain_q <= drain_q - 1'b1;
               if (drain_q == '0) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Beat issue, straight from the counters
   assign rd_addr = {row_q, fold_q};
   assign rd_fold = fold_q;
   assign stream  = (state_q == RUN) || (state_q == END);
   // Clear on first fold of each row
   assign sf_clr  = (state_q == RUN) && (fold_q == '0);
   assign sf_end  = state_q == END;
   assign busy    = state_q != IDLE;

endmodule

// ==== source/mvu_pe_simd.sv ====
//**********************************************************
// MVU PE SIMD stage
// Lane multipliers and adder tree, two register stages
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_simd (
   input  logic              aclk,
   input  logic              aresetn,
   input  mvu_pe_pkg::beat_t beat,
   output mvu_pe_pkg::acc_t  in_acc
);
   import mvu_pe_pkg::*;

   localparam int SIMD = `MVU_SIMD;
   localparam int TW   = `MVU_TW;
   localparam int TI   = `MVU_TI;

   prod_t w_ext  [SIMD];
   prod_t a_ext  [SIMD];
   prod_t prod_q [SIMD];
   acc_t  pair_sum [SIMD/2];
   acc_t  tree_sum;

   // Weight sign-extended, activation zero-extended
   always_comb begin
      for (int i = 0; i < SIMD; i++) begin
         w_ext[i] = prod_t'($signed(beat.weights[i*TW +: TW]));
         a_ext[i] = prod_t'(beat.acts[i*TI +: TI]);
      end
   end

   // Stage one, lane products
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         prod_q <= '{default: '0};
      end else begin
         for (int i = 0; i < SIMD; i++) begin
            prod_q[i] <= w_ext[i] * a_ext[i];
         end
      end
   end

   // Adder tree, first level pairs neighbouring lanes
   always_comb begin
      tree_sum = '0;
      for (int j = 0; j < SIMD/2; j++) begin
         pair_sum[j] = acc_t'(prod_q[2*j]) + acc_t'(prod_q[2*j+1]);
         tree_sum    = tree_sum + pair_sum[j];
      end
   end

   // Stage two, fold sum to the accumulator
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         in_acc <= '0;
      end else begin
         in_acc <= tree_sum;
      end
   end

endmodule

// ==== source/mvu_pe_acc.sv ====
//**********************************************************
// MVU PE accumulator
// Sums folds of a row and reports one dot product per row
//**********************************************************
`timescale 1ns/1ps

module mvu_pe_acc (
   input  logic                aclk,
   input  logic                aresetn,
   input  logic                do_mvau_stream,
   input  logic                sf_clr,
   input  logic                sf_end,
   input  mvu_pe_pkg::acc_t    in_acc,
   output mvu_pe_pkg::result_t result
);
   import mvu_pe_pkg::*;

   // Flag delay lines, index 1 lines up with in_acc
   logic [1:0] stream_dly;
   logic [1:0] clr_dly;
   logic [1:0] end_dly;
   logic       held_q;
   acc_t       acc_q;
   logic       report;
   logic       accum;
   logic       res_valid_q;
   acc_t       res_data_q;

   // Closing beat of a row while a sum is held
   assign report = stream_dly[1] & (clr_dly[1] | end_dly[1]) & held_q;
   // End beat carries no data
   assign accum  = stream_dly[1] & ~end_dly[1];

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         stream_dly  <= '0;
         clr_dly     <= '0;
         end_dly     <= '0;
         held_q      <= 1'b0;
         acc_q       <= '0;
         res_valid_q <= 1'b0;
      end else begin
         stream_dly  <= {stream_dly[0], do_mvau_stream};
         clr_dly     <= {clr_dly[0], sf_clr};
         end_dly     <= {end_dly[0], sf_end};
         res_valid_q <= report;
         if (accum) begin
            // Load on first fold, add otherwise
            acc_q  <= clr_dly[1] ? in_acc : acc_q + in_acc;
            held_q <= 1'b1;
         end else if (report) begin
            held_q <= 1'b0;
         end
      end
   end

   // Complete row sum, captured before the next load lands
   always_ff @(posedge aclk) begin
      if (report) begin
         res_data_q <= acc_q;
      end
   end

   assign result.valid = res_valid_q;
   assign result.data  = res_data_q;

endmodule

// ==== source/mvu_pe_top.sv ====
//**********************************************************
// MVU processing element
// APB loaded matrix-vector multiply, one result per row
//**********************************************************
`timescale 1ns/1ps

module mvu_pe_top (
   input  logic                 aclk,
   input  logic                 aresetn,
   input  mvu_pe_pkg::apb_req_t apb_req,
   output mvu_pe_pkg::apb_rsp_t apb_rsp,
   output mvu_pe_pkg::result_t  result
);
   import mvu_pe_pkg::*;

   // Host side
   logic         busy;
   logic         start;
   logic         wr_en;
   logic         act_sel;
   buf_addr_t    wr_addr;
   weight_word_t wr_data;
   weight_word_t rd_data;

   // Compute side
   buf_addr_t    rd_addr;
   fold_idx_t    rd_fold;
   logic         stream;
   logic         sf_clr;
   logic         sf_end;
   beat_t        beat;
   acc_t         in_acc;

   mvu_pe_apb_regs i_mvu_pe_apb_regs (
      .aclk    (aclk),
      .aresetn (aresetn),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .busy    (busy),
      .start   (start),
      .wr_en   (wr_en),
      .act_sel (act_sel),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_data (rd_data)
   );

   mvu_pe_buffer i_mvu_pe_buffer (
      .aclk    (aclk),
      .aresetn (aresetn),
      .wr_en   (wr_en),
      .act_sel (act_sel),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .rd_addr (rd_addr),
      .rd_fold (rd_fold),
      .stream  (stream),
      .sf_clr  (sf_clr),
      .sf_end  (sf_end),
      .beat    (beat)
   );

   mvu_pe_ctrl i_mvu_pe_ctrl (
      .aclk    (aclk),
      .aresetn (aresetn),
      .start   (start),
      .busy    (busy),
      .rd_addr (rd_addr),
      .rd_fold (rd_fold),
      .stream  (stream),
      .sf_clr  (sf_clr),
      .sf_end  (sf_end)
   );

   mvu_pe_simd i_mvu_pe_simd (
      .aclk    (aclk),
      .aresetn (aresetn),
      .beat    (beat),
      .in_acc  (in_acc)
   );

   // Flags enter straight from the beat, delayed inside
   mvu_pe_acc i_mvu_pe_acc (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .do_mvau_stream (beat.stream),
      .sf_clr         (beat.sf_clr),
      .sf_end         (beat.sf_end),
      .in_acc         (in_acc),
      .result         (result)
   );

endmodule

// ==== dv/mvu_pe_sva.sv ====
//**********************************************************
// MVU PE assertions
// APB handshake, start/busy and result pipeline checks
//**********************************************************
`timescale 1ns/1ps

module mvu_pe_sva (
   input logic                 aclk,
   input logic                 aresetn,
   input mvu_pe_pkg::apb_req_t apb_req,
   input mvu_pe_pkg::apb_rsp_t apb_rsp,
   input mvu_pe_pkg::result_t  result,
   input logic                 busy,
   input logic                 start
);
   // Failure count, read by the testbench at the end
   int fail_cnt = 0;

   // Setup phase moves on to access with psel held
   a_psel_held: assert property (@(posedge aclk) disable iff (!aresetn)
      apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
      else begin
         fail_cnt++;
         $error("psel not held into the access phase");
      end

   a_penable_psel: assert property (@(posedge aclk) disable iff (!aresetn)
      apb_req.penable |-> apb_req.psel)
      else begin
         fail_cnt++;
         $error("penable high without psel");
      end

   // Zero wait states
   a_pready: assert property (@(posedge aclk) disable iff (!aresetn)
      apb_req.psel && apb_req.penable |-> apb_rsp.pready)
      else begin
         fail_cnt++;
         $error("pready low in an access cycle");
      end

   a_start_busy: assert property (@(posedge aclk) disable iff (!aresetn)
      start |=> busy)
      else begin
         fail_cnt++;
         $error("start not followed by busy");
      end

   // Idle for five cycles means the pipeline is empty
   a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
      !busy && !$past(busy) && !$past(busy, 2) && !$past(busy, 3) && !$past(busy, 4)
      |-> !result.valid)
      else begin
         fail_cnt++;
         $error("result valid after busy stayed low");
      end

   // One valid cycle per row
   a_valid_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
      result.valid |=> !result.valid)
      else begin
         fail_cnt++;
         $error("result valid held for two cycles");
      end

endmodule

bind mvu_pe_top mvu_pe_sva i_mvu_pe_sva (
   .aclk    (aclk),
   .aresetn (aresetn),
   .apb_req (apb_req),
   .apb_rsp (apb_rsp),
   .result  (result),
   .busy    (busy),
   .start   (start)
);

// ==== dv/mvu_pe_checker.sv ====
//**********************************************************
// MVU PE checker
// Compares APB responses and row results with expectations
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_checker (
   input  logic                           aclk,
   input  logic                           aresetn,
   input  mvu_pe_pkg::apb_req_t           apb_req,
   input  mvu_pe_pkg::apb_rsp_t           apb_rsp,
   input  mvu_pe_pkg::result_t            result,
   input  logic [`MVU_APB_DW-1:0]         exp_prdata,
   input  logic                           chk_prdata,
   input  logic                           exp_pslverr,
   input  logic [`MVU_ROWS*`MVU_TDST-1:0] exp_rows,
   output int                             data_errs,
   output int                             proto_errs
);
   import mvu_pe_pkg::*;

   // Cycles after the access cycle of an accepted start
   localparam int FIRST_SLOT = 9;
   localparam int ROW_GAP    = `MVU_SF;
   localparam int LAST_SLOT  = FIRST_SLOT + ROW_GAP * (`MVU_ROWS - 1);
   localparam int RUN_DONE   = LAST_SLOT + 1;

   logic run_on;
   logic access;
   logic exp_busy;
   int   cyc;
   int   seen;
   int   row;
   acc_t exp_data;

   assign access = apb_req.psel & apb_req.penable;

   // Sampled mid cycle, away from the driving edge
   always @(negedge aclk) begin
      if (!aresetn) begin
         run_on     = 1'b0;
         cyc        = 0;
         seen       = 0;
         data_errs  = 0;
         proto_errs = 0;
      end else begin
         if (run_on) begin
            cyc++;
         end
         // Results only in the row slots of a run
         if (result.valid) begin
            if (!run_on || cyc < FIRST_SLOT || cyc > LAST_SLOT ||
                (cyc - FIRST_SLOT) % ROW_GAP != 0) begin
               $display("Unexpected result at %0t outside a row slot of a run", $time);
               proto_errs++;
            end else begin
               row      = (cyc - FIRST_SLOT) / ROW_GAP;
               exp_data = exp_rows[row*`MVU_TDST +: `MVU_TDST];
               if (result.data !== exp_data) begin
                  $display("Error %0t: result.data row %0d is %0d, expected %0d",
                           $time, row, $signed(result.data), $signed(exp_data));
                  data_errs++;
               end
               seen++;
            end
         end
         if (run_on && cyc == RUN_DONE) begin
            if (seen != `MVU_ROWS) begin
               $display("Run ended at %0t with %0d of %0d row results", $time, seen, `MVU_ROWS);
               proto_errs++;
            end
            run_on = 1'b0;
         end
         if (access) begin
            if (apb_rsp.pslverr !== exp_pslverr) begin
               $display("Error %0t: apb_rsp.pslverr at 0x%03h is %0b, expected %0b",
                        $time, apb_req.paddr, apb_rsp.pslverr, exp_pslverr);
               proto_errs++;
            end
            // Busy follows the run schedule
            if (!apb_req.pwrite && apb_req.paddr == `MVU_ADDR_STAT) begin
               exp_busy = run_on && cyc >= 1 && cyc <= LAST_SLOT;
               if (apb_rsp.prdata !== {{(`MVU_APB_DW-1){1'b0}}, exp_busy}) begin
                  $display("Error %0t: apb_rsp.prdata status is 0x%08h, expected 0x%08h",
                           $time, apb_rsp.prdata, {{(`MVU_APB_DW-1){1'b0}}, exp_busy});
                  proto_errs++;
               end
            end else if (!apb_req.pwrite && chk_prdata && apb_rsp.prdata !== exp_prdata) begin
               $display("Error %0t: apb_rsp.prdata at 0x%03h is 0x%08h, expected 0x%08h",
                        $time, apb_req.paddr, apb_rsp.prdata, exp_prdata);
               data_errs++;
            end
            // Accepted start opens a new run window
            if (apb_req.pwrite && apb_req.paddr == `MVU_ADDR_CTRL &&
                apb_req.pwdata[0] && !exp_pslverr) begin
               run_on = 1'b1;
               cyc    = 0;
               seen   = 0;
            end
         end
      end
   end

endmodule

// ==== dv/mvu_pe_tb.sv ====
//**********************************************************
// MVU PE testbench
// Table of matrix cases over APB, checked against a model
//**********************************************************
`timescale 1ns/1ps
`include "mvu_pe_config.svh"

module mvu_pe_tb;
   import mvu_pe_pkg::*;

   localparam int CASES        = 5;
   localparam int WORDS        = `MVU_ROWS * `MVU_SF;
   localparam int AW           = `MVU_APB_AW;
   localparam int DW           = `MVU_APB_DW;
   localparam int RESET_CYCLES = 16;
   localparam int APB_CYCLES   = 2;
   // Load and readback of every word, then start and status polls
   localparam int RUN_CYCLES   = 2 * APB_CYCLES * (WORDS + `MVU_SF) + 30;
   // Reset checks, five table runs and the rewritten run, doubled
   localparam int TIMEOUT_CYCLES =
      2 * (RESET_CYCLES + APB_CYCLES * (WORDS + `MVU_SF + 3) + (CASES + 1) * RUN_CYCLES);

   logic                           aclk;
   logic                           aresetn;
   apb_req_t                       apb_req;
   apb_rsp_t                       apb_rsp;
   result_t                        result;

   // Expectations for the checker
   logic [DW-1:0]                  exp_prdata;
   logic                           chk_prdata;
   logic                           exp_pslverr;
   logic [`MVU_ROWS*`MVU_TDST-1:0] exp_rows;
   int                             data_errs;
   int                             proto_errs;
   int                             sva_errs;

   // Stimulus table, row sums filled in by the model
   weight_word_t                   tbl_wgt [CASES][WORDS];
   act_word_t                      tbl_act [CASES][`MVU_SF];
   logic [`MVU_ROWS*`MVU_TDST-1:0] tbl_exp [CASES];
   weight_word_t                   cur_wgt [WORDS];
   act_word_t                      cur_act [`MVU_SF];
   int                             seed;
   int                             cycle_cnt;
   logic [DW-1:0]                  rdata;

   mvu_pe_top i_mvu_pe_top (
      .aclk    (aclk),
      .aresetn (aresetn),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .result  (result)
   );

   mvu_pe_checker i_mvu_pe_checker (
      .aclk        (aclk),
      .aresetn     (aresetn),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .result      (result),
      .exp_prdata  (exp_prdata),
      .chk_prdata  (chk_prdata),
      .exp_pslverr (exp_pslverr),
      .exp_rows    (exp_rows),
      .data_errs   (data_errs),
      .proto_errs  (proto_errs)
   );

   initial begin
      aclk = 1'b0;
      forever #10 aclk = ~aclk;
   end

   function automatic logic [AW-1:0] word_addr(input logic [AW-1:0] base, input int idx);
      return base + AW'(4 * idx);
   endfunction

   // Signed weight times unsigned activation, summed over a row, wrapped
   function automatic logic [`MVU_TDST-1:0] row_sum(input int row);
      int sum;
      int w;
      int a;
      sum = 0;
      for (int f = 0; f < `MVU_SF; f++) begin
         for (int l = 0; l < `MVU_SIMD; l++) begin
            w = int'($signed(cur_wgt[row*`MVU_SF+f][l*`MVU_TW +: `MVU_TW]));
            a = int'(cur_act[f][l*`MVU_TI +: `MVU_TI]);
            sum += w * a;
         end
      end
      return sum[`MVU_TDST-1:0];
   endfunction

   function automatic logic [`MVU_ROWS*`MVU_TDST-1:0] model_rows();
      logic [`MVU_ROWS*`MVU_TDST-1:0] rows;
      for (int r = 0; r < `MVU_ROWS; r++) begin
         rows[r*`MVU_TDST +: `MVU_TDST] = row_sum(r);
      end
      return rows;
   endfunction

   task automatic select_case(input int c);
      for (int i = 0; i < WORDS; i++) begin
         cur_wgt[i] = tbl_wgt[c][i];
      end
      for (int f = 0; f < `MVU_SF; f++) begin
         cur_act[f] = tbl_act[c][f];
      end
   endtask

   // Zeros, max positive, min negative, mixed signs, random
   task automatic fill_table();
      seed = 32'h9717;
      for (int i = 0; i < WORDS; i++) begin
         tbl_wgt[0][i] = '0;
         tbl_wgt[1][i] = 16'h7777;
         tbl_wgt[2][i] = 16'h8888;
         tbl_wgt[3][i] = 16'h9F71 ^ weight_word_t'(i * 16'h1111);
         tbl_wgt[4][i] = weight_word_t'($random(seed));
      end
      for (int f = 0; f < `MVU_SF; f++) begin
         tbl_act[0][f] = '0;
         tbl_act[1][f] = 16'hFFFF;
         tbl_act[2][f] = 16'hFFFF;
         tbl_act[3][f] = 16'h3C5A + act_word_t'(f * 16'h2461);
         tbl_act[4][f] = act_word_t'($random(seed));
      end
      for (int c = 0; c < CASES; c++) begin
         select_case(c);
         tbl_exp[c] = model_rows();
      end
   endtask

   // One APB transfer, entered and left 2 ns after a rising edge
   task automatic apb_xfer(input logic wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wdata, input logic [DW-1:0] exp_data,
                           input logic chk, input logic err, output logic [DW-1:0] data);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      exp_prdata      = exp_data;
      chk_prdata      = chk;
      exp_pslverr     = err;
      @(posedge aclk);
      #2;
      apb_req.penable = 1'b1;
      @(negedge aclk);
      data = apb_rsp.prdata;
      @(posedge aclk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   // Writes, then readback of the same words
   task automatic load_buffer(input logic acts_only);
      for (int i = 0; i < WORDS && !acts_only; i++) begin
         apb_xfer(1'b1, word_addr(`MVU_ADDR_WGT, i), DW'(cur_wgt[i]), '0, 1'b0, 1'b0, rdata);
      end
      for (int f = 0; f < `MVU_SF; f++) begin
         apb_xfer(1'b1, word_addr(`MVU_ADDR_ACT, f), DW'(cur_act[f]), '0, 1'b0, 1'b0, rdata);
      end
      for (int i = 0; i < WORDS && !acts_only; i++) begin
         apb_xfer(1'b0, word_addr(`MVU_ADDR_WGT, i), '0, DW'(cur_wgt[i]), 1'b1, 1'b0, rdata);
      end
      for (int f = 0; f < `MVU_SF; f++) begin
         apb_xfer(1'b0, word_addr(`MVU_ADDR_ACT, f), '0, DW'(cur_act[f]), 1'b1, 1'b0, rdata);
      end
   endtask

   // Start, optional second start while busy, poll until idle
   task automatic run_matrix(input logic poke_busy);
      apb_xfer(1'b1, `MVU_ADDR_CTRL, DW'(1), '0, 1'b0, 1'b0, rdata);
      if (poke_busy) begin
         apb_xfer(1'b1, `MVU_ADDR_CTRL, DW'(1), '0, 1'b0, 1'b1, rdata);
      end
      do begin
         apb_xfer(1'b0, `MVU_ADDR_STAT, '0, '0, 1'b0, 1'b0, rdata);
      end while (rdata[0]);
   endtask

   initial begin
      aresetn     = 1'b0;
      apb_req     = '0;
      exp_prdata  = '0;
      chk_prdata  = 1'b0;
      exp_pslverr = 1'b0;
      exp_rows    = '0;
      fill_table();
      repeat (RESET_CYCLES) @(posedge aclk);
      #2;
      aresetn = 1'b1;
      // Idle status and cleared storage
      apb_xfer(1'b0, `MVU_ADDR_STAT, '0, '0, 1'b0, 1'b0, rdata);
      for (int i = 0; i < WORDS; i++) begin
         apb_xfer(1'b0, word_addr(`MVU_ADDR_WGT, i), '0, '0, 1'b1, 1'b0, rdata);
      end
      for (int f = 0; f < `MVU_SF; f++) begin
         apb_xfer(1'b0, word_addr(`MVU_ADDR_ACT, f), '0, '0, 1'b1, 1'b0, rdata);
      end
      // Holes in the map
      apb_xfer(1'b0, 12'h050, '0, '0, 1'b0, 1'b1, rdata);
      apb_xfer(1'b1, 12'h100, DW'(1), '0, 1'b0, 1'b1, rdata);
      for (int c = 0; c < CASES; c++) begin
         select_case(c);
         exp_rows = tbl_exp[c];
         load_buffer(1'b0);
         // Mixed case also sees a start while busy
         run_matrix(c == 3);
      end
      // Same weights, new activations, straight after the last run
      for (int f = 0; f < `MVU_SF; f++) begin
         cur_act[f] = ~cur_act[f];
      end
      exp_rows = model_rows();
      load_buffer(1'b1);
      run_matrix(1'b0);
      repeat (4) @(posedge aclk);
      sva_errs = i_mvu_pe_top.i_mvu_pe_sva.fail_cnt;
      $display("Errors: %0d data, %0d protocol, %0d assertion", data_errs, proto_errs, sva_errs);
      if (data_errs + proto_errs + sva_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge aclk);
         cycle_cnt++;
      end
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== mvu_pe_top.f ====
+incdir+include
source/mvu_pe_pkg.sv
source/mvu_pe_apb_regs.sv
source/mvu_pe_buffer.sv
source/mvu_pe_ctrl.sv
source/mvu_pe_simd.sv
source/mvu_pe_acc.sv
source/mvu_pe_top.sv
dv/mvu_pe_sva.sv
dv/mvu_pe_checker.sv
dv/mvu_pe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MVU PE testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mvu_pe_tb \
   -f mvu_pe_top.f -o mvu_pe_sim || exit 1
# Assertion failures count toward the result instead of stopping the run
out=$(./obj_dir/mvu_pe_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && exit 0 || exit 1
